//--- common/conv_pkg.sv
package conv_pkg;

	// image and kernel geometry
	localparam int IMG_WIDTH    = 8;
	localparam int KERNEL_SIZE  = 3;
	localparam int KERNEL_TAPS  = KERNEL_SIZE * KERNEL_SIZE;
	localparam int OUT_CHANNELS = 4;
	localparam int WEIGHT_COUNT = OUT_CHANNELS * KERNEL_TAPS;
	localparam int ADDR_WIDTH   = 16;
	localparam int WORD_WIDTH   = 16;

	// words between the end of one window row and the start of the next
	localparam int LINE_DELAY = IMG_WIDTH - KERNEL_SIZE;

	typedef logic signed [WORD_WIDTH-1:0] pixel_t;
	typedef logic signed [WORD_WIDTH-1:0] weight_t;
	typedef logic signed [WORD_WIDTH-1:0] bias_t;
	typedef logic [ADDR_WIDTH-1:0] addr_t;

	// window[row][col], row 0 is the oldest line
	typedef pixel_t [KERNEL_SIZE-1:0][KERNEL_SIZE-1:0] window_t;
	typedef pixel_t [OUT_CHANNELS-1:0] feature_t;

	localparam addr_t LAST_POS   = addr_t'(IMG_WIDTH - 1);
	localparam addr_t WIN_OFFSET = addr_t'(KERNEL_SIZE - 1);
	localparam addr_t LAST_WIN   = addr_t'(IMG_WIDTH - KERNEL_SIZE);

	typedef enum logic {SEQ_IDLE, SEQ_READ} seq_state_t;
	typedef enum logic [1:0] {COEF_IDLE, COEF_READ, COEF_DONE} coef_state_t;

endpackage

//--- design/frame_sequencer.sv
`timescale 1ns/1ps

module frame_sequencer (
	input  logic            clk,
	input  logic            rst,
	input  logic            pixel_store_done,
	output conv_pkg::addr_t read_row_addr,
	output conv_pkg::addr_t read_col_addr,
	output logic            read_pixel_signal,
	output logic            pixel_valid,
	output logic            save_enable,
	output conv_pkg::addr_t output_row,
	output conv_pkg::addr_t output_col,
	output logic            calc_done
);

	conv_pkg::seq_state_t state;
	conv_pkg::addr_t      row_cnt;
	conv_pkg::addr_t      col_cnt;
	logic                 last_col;
	logic                 last_pixel;

	// position of the pixel coming back from the store
	conv_pkg::addr_t      pix_row;
	conv_pkg::addr_t      pix_col;

	// top-left corner of the window now held in pixel_window
	logic                 win_valid;
	conv_pkg::addr_t      win_row;
	conv_pkg::addr_t      win_col;

	assign read_row_addr     = row_cnt;
	assign read_col_addr     = col_cnt;
	assign read_pixel_signal = (state == conv_pkg::SEQ_READ);
	assign last_col          = (col_cnt == conv_pkg::LAST_POS);
	assign last_pixel        = last_col && (row_cnt == conv_pkg::LAST_POS);

	// raster read of one frame, start pulses ignored while busy
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			state   <= conv_pkg::SEQ_IDLE;
			row_cnt <= '0;
			col_cnt <= '0;
		end
		else
		begin
			case (state)
				conv_pkg::SEQ_IDLE:
				begin
					if (pixel_store_done)
						state <= conv_pkg::SEQ_READ;
				end
				conv_pkg::SEQ_READ:
				begin
					if (last_pixel)
					begin
						state   <= conv_pkg::SEQ_IDLE;
						row_cnt <= '0;
						col_cnt <= '0;
					end
					else if (last_col)
					begin
						row_cnt <= row_cnt + 1'b1;
						col_cnt <= '0;
					end
					else
						col_cnt <= col_cnt + 1'b1;
				end
				default:
					state <= conv_pkg::SEQ_IDLE;
			endcase
		end
	end

	// store answers one cycle after the read
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			pixel_valid <= 1'b0;
			pix_row     <= '0;
			pix_col     <= '0;
		end
		else
		begin
			pixel_valid <= read_pixel_signal;
			pix_row     <= row_cnt;
			pix_col     <= col_cnt;
		end
	end

	// window is full once the newest pixel is at row >= 2 and col >= 2
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			win_valid <= 1'b0;
			win_row   <= '0;
			win_col   <= '0;
		end
		else
		begin
			win_valid <= pixel_valid && (pix_row >= conv_pkg::WIN_OFFSET)
				&& (pix_col >= conv_pkg::WIN_OFFSET);
			win_row   <= pix_row - conv_pkg::WIN_OFFSET;
			win_col   <= pix_col - conv_pkg::WIN_OFFSET;
		end
	end

	// one stage to line up with the mac register
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			save_enable <= 1'b0;
			calc_done   <= 1'b0;
			output_row  <= '0;
			output_col  <= '0;
		end
		else
		begin
			save_enable <= win_valid;
			calc_done   <= win_valid && (win_row == conv_pkg::LAST_WIN)
				&& (win_col == conv_pkg::LAST_WIN);
			if (win_valid)
			begin
				output_row <= win_row;
				output_col <= win_col;
			end
		end
	end

endmodule

//--- window/pixel_window.sv
`timescale 1ns/1ps

module pixel_window (
	input  logic              clk,
	input  logic              rst,
	input  logic              pixel_valid,
	input  conv_pkg::pixel_t  pixel_data,
	output conv_pkg::window_t window
);

	// line_buf[0] feeds the middle row, line_buf[1] the top row
	conv_pkg::pixel_t line_buf [conv_pkg::KERNEL_SIZE-1][conv_pkg::LINE_DELAY];

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			window <= '0;
			for (int k = 0; k < conv_pkg::KERNEL_SIZE - 1; k++)
			begin
				for (int d = 0; d < conv_pkg::LINE_DELAY; d++)
				begin
					line_buf[k][d] <= '0;
				end
			end
		end
		else if (pixel_valid)
		begin
			// every row moves one column left
			for (int r = 0; r < conv_pkg::KERNEL_SIZE; r++)
			begin
				for (int c = 0; c < conv_pkg::KERNEL_SIZE - 1; c++)
				begin
					window[r][c] <= window[r][c+1];
				end
			end

			// newest pixel enters the bottom right
			window[conv_pkg::KERNEL_SIZE-1][conv_pkg::KERNEL_SIZE-1] <= pixel_data;

			// the leftmost word of a row goes through a line delay
			// and reappears at the right end of the row above
			for (int k = 0; k < conv_pkg::KERNEL_SIZE - 1; k++)
			begin
				line_buf[k][0] <= window[conv_pkg::KERNEL_SIZE-1-k][0];
				for (int d = 1; d < conv_pkg::LINE_DELAY; d++)
				begin
					line_buf[k][d] <= line_buf[k][d-1];
				end
				window[conv_pkg::KERNEL_SIZE-2-k][conv_pkg::KERNEL_SIZE-1] <=
					line_buf[k][conv_pkg::LINE_DELAY-1];
			end
		end
	end

endmodule

//--- coef/coef_chain.sv
`timescale 1ns/1ps

module coef_chain #(
	parameter type payload_t = conv_pkg::weight_t,
	parameter int  DEPTH     = conv_pkg::OUT_CHANNELS
) (
	input  logic            clk,
	input  logic            rst,
	input  logic            store_done,
	input  payload_t        data,
	output logic            read_signal,
	output conv_pkg::addr_t read_addr,
	output payload_t        coefs [DEPTH],
	output logic            loaded
);

	conv_pkg::coef_state_t state;
	conv_pkg::addr_t       read_cnt;
	logic                  take;

	assign read_signal = (state == conv_pkg::COEF_READ);
	assign read_addr   = read_cnt;

	// one pass over addresses 0 .. DEPTH-1, then done until reset
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			state    <= conv_pkg::COEF_IDLE;
			read_cnt <= '0;
		end
		else
		begin
			case (state)
				conv_pkg::COEF_IDLE:
				begin
					if (store_done)
						state <= conv_pkg::COEF_READ;
				end
				conv_pkg::COEF_READ:
				begin
					if (read_cnt == conv_pkg::addr_t'(DEPTH - 1))
					begin
						state    <= conv_pkg::COEF_DONE;
						read_cnt <= '0;
					end
					else
						read_cnt <= read_cnt + 1'b1;
				end
				default:
					state <= conv_pkg::COEF_DONE;
			endcase
		end
	end

	// data word returns a cycle after its read
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			take   <= 1'b0;
			loaded <= 1'b0;
		end
		else
		begin
			take <= read_signal;
			if (take && state == conv_pkg::COEF_DONE)
				loaded <= 1'b1;
		end
	end

	// enters at the top, so address k settles in coefs[k]
	always_ff @(posedge clk)
	begin
		if (take && !loaded)
		begin
			coefs[DEPTH-1] <= data;
			for (int k = 0; k < DEPTH - 1; k++)
			begin
				coefs[k] <= coefs[k+1];
			end
		end
	end

endmodule

//--- design/conv_mac.sv
`timescale 1ns/1ps

module conv_mac (
	input  logic               clk,
	input  logic               rst,
	input  conv_pkg::window_t  window,
	input  conv_pkg::weight_t  weights [conv_pkg::WEIGHT_COUNT],
	input  conv_pkg::bias_t    biases [conv_pkg::OUT_CHANNELS],
	output conv_pkg::feature_t feature
);

	conv_pkg::pixel_t prod [conv_pkg::OUT_CHANNELS][conv_pkg::KERNEL_TAPS];
	conv_pkg::pixel_t pair_sum [conv_pkg::OUT_CHANNELS][4];
	conv_pkg::pixel_t quad_sum [conv_pkg::OUT_CHANNELS][2];
	conv_pkg::pixel_t tail_sum [conv_pkg::OUT_CHANNELS];
	conv_pkg::pixel_t chan_sum [conv_pkg::OUT_CHANNELS];

	// everything wraps at 16 bits
	always_comb
	begin
		for (int ch = 0; ch < conv_pkg::OUT_CHANNELS; ch++)
		begin
			for (int tap = 0; tap < conv_pkg::KERNEL_TAPS; tap++)
			begin
				prod[ch][tap] = window[tap / conv_pkg::KERNEL_SIZE][tap % conv_pkg::KERNEL_SIZE]
					* weights[ch * conv_pkg::KERNEL_TAPS + tap];
			end

			// taps 0..7 pairwise, tap 8 joins the bias
			for (int i = 0; i < 4; i++)
			begin
				pair_sum[ch][i] = prod[ch][2*i] + prod[ch][2*i+1];
			end
			for (int j = 0; j < 2; j++)
			begin
				quad_sum[ch][j] = pair_sum[ch][2*j] + pair_sum[ch][2*j+1];
			end
			tail_sum[ch] = prod[ch][conv_pkg::KERNEL_TAPS-1] + biases[ch];
			chan_sum[ch] = quad_sum[ch][0] + quad_sum[ch][1] + tail_sum[ch];
		end
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
			feature <= '0;
		else
		begin
			for (int ch = 0; ch < conv_pkg::OUT_CHANNELS; ch++)
			begin
				feature[ch] <= chan_sum[ch];
			end
		end
	end

endmodule

//--- design/conv_top.sv
`timescale 1ns/1ps

module conv_top (
	input  logic               clk,
	input  logic               rst,
	input  logic               pixel_store_done,
	input  logic               weight_store_done,
	input  logic               bias_store_done,
	input  conv_pkg::pixel_t   pixel_data,
	input  conv_pkg::weight_t  weight_data,
	input  conv_pkg::bias_t    bias_data,
	output conv_pkg::addr_t    read_row_addr,
	output conv_pkg::addr_t    read_col_addr,
	output logic               read_pixel_signal,
	output conv_pkg::addr_t    read_weight_addr,
	output conv_pkg::addr_t    read_bias_addr,
	output logic               read_weight_signal,
	output logic               read_bias_signal,
	output logic               save_enable,
	output conv_pkg::addr_t    output_row,
	output conv_pkg::addr_t    output_col,
	output conv_pkg::feature_t output_data,
	output logic               calc_done
);

	logic                pixel_valid;
	conv_pkg::window_t   window;
	conv_pkg::weight_t   weights [conv_pkg::WEIGHT_COUNT];
	conv_pkg::bias_t     biases [conv_pkg::OUT_CHANNELS];
	// load status, observed by the protocol checker
	logic                weights_loaded;
	logic                biases_loaded;

	frame_sequencer i_frame_sequencer (
		.clk               (clk),
		.rst               (rst),
		.pixel_store_done  (pixel_store_done),
		.read_row_addr     (read_row_addr),
		.read_col_addr     (read_col_addr),
		.read_pixel_signal (read_pixel_signal),
		.pixel_valid       (pixel_valid),
		.save_enable       (save_enable),
		.output_row        (output_row),
		.output_col        (output_col),
		.calc_done         (calc_done)
	);

	pixel_window i_pixel_window (
		.clk         (clk),
		.rst         (rst),
		.pixel_valid (pixel_valid),
		.pixel_data  (pixel_data),
		.window      (window)
	);

	coef_chain #(
		.payload_t (conv_pkg::weight_t),
		.DEPTH     (conv_pkg::WEIGHT_COUNT)
	) i_weight_chain (
		.clk         (clk),
		.rst         (rst),
		.store_done  (weight_store_done),
		.data        (weight_data),
		.read_signal (read_weight_signal),
		.read_addr   (read_weight_addr),
		.coefs       (weights),
		.loaded      (weights_loaded)
	);

	coef_chain #(
		.payload_t (conv_pkg::bias_t),
		.DEPTH     (conv_pkg::OUT_CHANNELS)
	) i_bias_chain (
		.clk         (clk),
		.rst         (rst),
		.store_done  (bias_store_done),
		.data        (bias_data),
		.read_signal (read_bias_signal),
		.read_addr   (read_bias_addr),
		.coefs       (biases),
		.loaded      (biases_loaded)
	);

	conv_mac i_conv_mac (
		.clk     (clk),
		.rst     (rst),
		.window  (window),
		.weights (weights),
		.biases  (biases),
		.feature (output_data)
	);

endmodule

//--- test/conv_checker.sv
`timescale 1ns/1ps

module conv_checker (
	input logic            clk,
	input logic            rst,
	input logic            pixel_store_done,
	input logic            weight_store_done,
	input logic            bias_store_done,
	input logic            read_pixel_signal,
	input logic            read_weight_signal,
	input logic            read_bias_signal,
	input conv_pkg::addr_t read_weight_addr,
	input conv_pkg::addr_t read_bias_addr,
	input logic            save_enable,
	input conv_pkg::addr_t output_row,
	input conv_pkg::addr_t output_col,
	input logic            calc_done,
	input logic            weights_loaded,
	input logic            biases_loaded
);

	int   failures = 0;
	logic frame_seen;

	// any pixel read so far
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
			frame_seen <= 1'b0;
		else if (read_pixel_signal)
			frame_seen <= 1'b1;
	end

	quiet_before_start: assert property (@(posedge clk) disable iff (rst)
		!frame_seen |-> !save_enable && !calc_done)
	else
	begin
		failures++;
		$error("output activity before any frame was read");
	end

	pixel_start: assert property (@(posedge clk) disable iff (rst)
		$rose(read_pixel_signal) |-> $past(pixel_store_done))
	else
	begin
		failures++;
		$error("pixel reads began without a start pulse");
	end

	weight_start: assert property (@(posedge clk) disable iff (rst)
		$rose(read_weight_signal) |-> $past(weight_store_done) && read_weight_addr == 0)
	else
	begin
		failures++;
		$error("weight load began without a start pulse or away from address 0");
	end

	bias_start: assert property (@(posedge clk) disable iff (rst)
		$rose(read_bias_signal) |-> $past(bias_store_done) && read_bias_addr == 0)
	else
	begin
		failures++;
		$error("bias load began without a start pulse or away from address 0");
	end

	weight_step: assert property (@(posedge clk) disable iff (rst)
		read_weight_signal && $past(read_weight_signal)
			|-> read_weight_addr == $past(read_weight_addr) + 1)
	else
	begin
		failures++;
		$error("weight addresses are not contiguous");
	end

	no_reload: assert property (@(posedge clk) disable iff (rst)
		(weights_loaded |-> !read_weight_signal) and (biases_loaded |-> !read_bias_signal))
	else
	begin
		failures++;
		$error("coefficients were read again after loading");
	end

	done_at_last: assert property (@(posedge clk) disable iff (rst)
		calc_done |-> save_enable && output_row == conv_pkg::LAST_WIN
			&& output_col == conv_pkg::LAST_WIN)
	else
	begin
		failures++;
		$error("calc_done away from the last window");
	end

endmodule

bind conv_top conv_checker i_conv_checker (.*);

//--- test/conv_tb.sv
`timescale 1ns/1ps

module conv_tb;

	localparam int PIXELS    = conv_pkg::IMG_WIDTH * conv_pkg::IMG_WIDTH;
	localparam int OUT_SIDE  = conv_pkg::IMG_WIDTH - conv_pkg::KERNEL_SIZE + 1;
	localparam int OUTPUTS   = OUT_SIDE * OUT_SIDE;
	localparam int FRAMES    = 2;
	// reset, both loads, three frames and some slack
	localparam int TIMEOUT_CYCLES = 8 + 2 * (conv_pkg::WEIGHT_COUNT + 8)
		+ 3 * (PIXELS + 20) + 200;

	logic               clk;
	logic               rst;
	logic               pixel_store_done;
	logic               weight_store_done;
	logic               bias_store_done;
	conv_pkg::pixel_t   pixel_data;
	conv_pkg::weight_t  weight_data;
	conv_pkg::bias_t    bias_data;
	conv_pkg::addr_t    read_row_addr;
	conv_pkg::addr_t    read_col_addr;
	logic               read_pixel_signal;
	conv_pkg::addr_t    read_weight_addr;
	conv_pkg::addr_t    read_bias_addr;
	logic               read_weight_signal;
	logic               read_bias_signal;
	logic               save_enable;
	conv_pkg::addr_t    output_row;
	conv_pkg::addr_t    output_col;
	conv_pkg::feature_t output_data;
	logic               calc_done;

	// store contents that the model reads too
	logic [15:0] img [FRAMES+1][PIXELS];
	logic [15:0] weight_mem [conv_pkg::WEIGHT_COUNT];
	logic [15:0] bias_mem [conv_pkg::OUT_CHANNELS];

	int errors;
	int read_idx;
	int read_frame;
	int save_idx;
	int save_frame;
	int total_saves;
	int weight_reads;
	int bias_reads;

	conv_top i_conv_top (.*);

	initial
	begin
		clk = 1'b0;
		forever
			#4 clk = ~clk;
	end

	// registered stores with one cycle read latency
	always @(posedge clk)
	begin
		if (read_pixel_signal)
			pixel_data <= img[read_frame][read_row_addr * conv_pkg::IMG_WIDTH + read_col_addr];
		if (read_weight_signal)
			weight_data <= weight_mem[read_weight_addr];
		if (read_bias_signal)
			bias_data <= bias_mem[read_bias_addr];
	end

	// progress counters for reads and saves
	always @(posedge clk)
	begin
		if (read_pixel_signal)
		begin
			if (read_idx == PIXELS - 1)
			begin
				read_idx   <= 0;
				read_frame <= read_frame + 1;
			end
			else
				read_idx <= read_idx + 1;
		end
		if (save_enable)
		begin
			total_saves <= total_saves + 1;
			if (save_idx == OUTPUTS - 1)
			begin
				save_idx   <= 0;
				save_frame <= save_frame + 1;
			end
			else
				save_idx <= save_idx + 1;
		end
		if (read_weight_signal)
			weight_reads <= weight_reads + 1;
		if (read_bias_signal)
			bias_reads <= bias_reads + 1;
	end

	// bias plus nine products cut to 16 bits with wrapping sums
	function automatic logic [63:0] expect_feature(int frame, int row, int col);
		logic [63:0]        result;
		logic signed [31:0] full;
		logic [15:0]        acc;
		int                 r;
		int                 c;
		result = '0;
		for (int ch = 0; ch < conv_pkg::OUT_CHANNELS; ch++)
		begin
			acc = bias_mem[ch];
			for (int tap = 0; tap < conv_pkg::KERNEL_TAPS; tap++)
			begin
				r    = row + tap / conv_pkg::KERNEL_SIZE;
				c    = col + tap % conv_pkg::KERNEL_SIZE;
				full = $signed(img[frame][r * conv_pkg::IMG_WIDTH + c])
					* $signed(weight_mem[ch * conv_pkg::KERNEL_TAPS + tap]);
				acc  = acc + full[15:0];
			end
			result[ch*16 +: 16] = acc;
		end
		return result;
	endfunction

	assert property (@(posedge clk) disable iff (rst)
		save_enable |-> output_data == expect_feature(save_frame, output_row, output_col))
	else
	begin
		errors++;
		$display("Mismatch output_data at (%0d,%0d): got %h expected %h",
			$sampled(output_row), $sampled(output_col), $sampled(output_data),
			expect_feature($sampled(save_frame), $sampled(output_row), $sampled(output_col)));
	end

	assert property (@(posedge clk) disable iff (rst)
		save_enable |-> output_row == save_idx / OUT_SIDE && output_col == save_idx % OUT_SIDE)
	else
	begin
		errors++;
		$display("Mismatch output_row/output_col: got %h/%h expected %h/%h",
			$sampled(output_row), $sampled(output_col),
			$sampled(save_idx) / OUT_SIDE, $sampled(save_idx) % OUT_SIDE);
	end

	assert property (@(posedge clk) disable iff (rst)
		calc_done == (save_enable && save_idx == OUTPUTS - 1))
	else
	begin
		errors++;
		$display("Mismatch calc_done: got %h expected %h", $sampled(calc_done),
			$sampled(save_enable) && $sampled(save_idx) == OUTPUTS - 1);
	end

	assert property (@(posedge clk) disable iff (rst)
		read_pixel_signal |-> read_row_addr == read_idx / conv_pkg::IMG_WIDTH
			&& read_col_addr == read_idx % conv_pkg::IMG_WIDTH)
	else
	begin
		errors++;
		$display("Mismatch read_row_addr/read_col_addr: got %h/%h expected %h/%h",
			$sampled(read_row_addr), $sampled(read_col_addr),
			$sampled(read_idx) / conv_pkg::IMG_WIDTH, $sampled(read_idx) % conv_pkg::IMG_WIDTH);
	end

	assert property (@(posedge clk) disable iff (rst)
		$fell(read_pixel_signal) |-> read_idx == 0)
	else
	begin
		errors++;
		$display("pixel read burst ended before covering the whole image");
	end

	assert property (@(posedge clk) disable iff (rst)
		read_weight_signal |-> read_weight_addr == weight_reads)
	else
	begin
		errors++;
		$display("Mismatch read_weight_addr: got %h expected %h",
			$sampled(read_weight_addr), $sampled(weight_reads));
	end

	assert property (@(posedge clk) disable iff (rst)
		read_bias_signal |-> read_bias_addr == bias_reads)
	else
	begin
		errors++;
		$display("Mismatch read_bias_addr: got %h expected %h",
			$sampled(read_bias_addr), $sampled(bias_reads));
	end

	task automatic start_frame;
		@(posedge clk);
		pixel_store_done <= 1'b1;
		@(posedge clk);
		pixel_store_done <= 1'b0;
	endtask

	task automatic count_check(string what, int got, int want);
		if (got != want)
		begin
			errors++;
			$display("Mismatch %s: got %h expected %h", what, got, want);
		end
	endtask

	initial
	begin
		repeat (TIMEOUT_CYCLES)
			@(posedge clk);
		$display("timeout: the run did not finish in %0d cycles", TIMEOUT_CYCLES);
		$display("CHECKS FAILED");
		$finish;
	end

	initial
	begin
		int total;
		void'($urandom(96));
		errors = 0;
		read_idx = 0;
		read_frame = 0;
		save_idx = 0;
		save_frame = 0;
		total_saves = 0;
		weight_reads = 0;
		bias_reads = 0;
		rst = 1'b1;
		pixel_store_done = 1'b0;
		weight_store_done = 1'b0;
		bias_store_done = 1'b0;
		pixel_data = '0;
		weight_data = '0;
		bias_data = '0;
		for (int f = 0; f <= FRAMES; f++)
			for (int i = 0; i < PIXELS; i++)
				img[f][i] = 16'($urandom);
		for (int i = 0; i < conv_pkg::WEIGHT_COUNT; i++)
			weight_mem[i] = 16'($urandom);
		for (int i = 0; i < conv_pkg::OUT_CHANNELS; i++)
			bias_mem[i] = 16'($urandom);
		repeat (8)
			@(posedge clk);
		rst <= 1'b0;
		repeat (4)
			@(posedge clk);

		weight_store_done <= 1'b1;
		bias_store_done   <= 1'b1;
		@(posedge clk);
		weight_store_done <= 1'b0;
		bias_store_done   <= 1'b0;
		do
			@(negedge clk);
		while (!(i_conv_top.weights_loaded && i_conv_top.biases_loaded));

		// first frame with a start pulse in the middle of it
		start_frame();
		repeat (20)
			@(posedge clk);
		start_frame();
		do
			@(negedge clk);
		while (read_pixel_signal);
		start_frame();
		do
			@(negedge clk);
		while (save_frame < FRAMES);
		// no stray outputs may follow
		repeat (30)
			@(negedge clk);

		count_check("read frames", read_frame, FRAMES);
		count_check("save_enable count", total_saves, FRAMES * OUTPUTS);
		count_check("weight reads", weight_reads, conv_pkg::WEIGHT_COUNT);
		count_check("bias reads", bias_reads, conv_pkg::OUT_CHANNELS);
		total = errors + i_conv_top.i_conv_checker.failures;
		$display("testbench errors: %0d, checker failures: %0d",
			errors, i_conv_top.i_conv_checker.failures);
		if (total == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

//--- all.f
common/conv_pkg.sv
design/frame_sequencer.sv
window/pixel_window.sv
coef/coef_chain.sv
design/conv_mac.sv
design/conv_top.sv
test/conv_checker.sv
test/conv_tb.sv

//--- Bender.yml
package:
  name: conv_layer

sources:
  - common/conv_pkg.sv
  - design/frame_sequencer.sv
  - window/pixel_window.sv
  - coef/coef_chain.sv
  - design/conv_mac.sv
  - design/conv_top.sv
  - target: test
    files:
      - test/conv_checker.sv
      - test/conv_tb.sv
